// ==== sources.f ====
+incdir+hw
+incdir+verification
hw/clint_pkg.sv
hw/clint_axi_wr_fsm.sv
hw/clint_axi_rd_fsm.sv
hw/clint_mtime_counter.sv
hw/clint_timer_compare.sv
hw/clint_top.sv
verification/clint_tb.sv

// ==== verification/clint_vectors.txt ====
# op addr data strb resp expected kind, numbers in hex
# op W write or R read; kind N none, E exact, S mtimecmp model, M mtime window since last write
R 0000000000004000 0000000000000000 00 0 0000000000000020 E
W 0000000000004000 1122334455667788 ff 0 0000000000000000 N
R 0000000000004000 0000000000000000 00 0 1122334455667788 E
W 0000000000004000 aabbccddeeff0011 0f 0 0000000000000000 N
R 0000000000004000 0000000000000000 00 0 11223344eeff0011 E
W 0000000000004000 9988776600000000 c0 0 0000000000000000 N
R 0000000000004000 0000000000000000 00 0 99883344eeff0011 S
W 0000000000004000 00005a0000a50000 24 0 0000000000000000 N
R 0000000000004000 0000000000000000 00 0 99885a44eea50011 E
W 0000000000004000 ffffffffffffffff 00 0 0000000000000000 N
R 0000000000004000 0000000000000000 00 0 99885a44eea50011 S
W 000000000000bff8 0000000000010000 ff 0 0000000000000000 N
R 000000000000bff8 0000000000000000 00 0 0000000000010000 M
W 0000000000001000 deadbeefdeadbeef ff 2 0000000000000000 N
R 0000000000001000 0000000000000000 00 2 0000000000000000 E
R 0000000000004000 0000000000000000 00 0 99885a44eea50011 S
W 0000000000004008 0f0f0f0f0f0f0f0f ff 2 0000000000000000 N
W 000000000000bffc 0f0f0f0f0f0f0f0f ff 2 0000000000000000 N
R 000000000000bff0 0000000000000000 00 2 0000000000000000 E
R 0000000000004000 0000000000000000 00 0 99885a44eea50011 E
W 0000000100004000 0123456789abcdef ff 0 0000000000000000 N
R 0000000000004000 0000000000000000 00 0 0123456789abcdef E
W 000000000000bff8 0000000123456789 ff 0 0000000000000000 N
R 000000000000bff8 0000000000000000 00 0 0000000123456789 M
R 0000000000004000 0000000000000000 00 0 0123456789abcdef S

// ==== verification/clint_tb_checks.svh ====
`ifndef CLINT_TB_CHECKS_SVH
`define CLINT_TB_CHECKS_SVH

// print what went wrong and end the run at the first error
task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "simulation stopped at first error");
endtask

task automatic check_resp(
    input string     name,
    input axi_resp_e expected,
    input axi_resp_e actual
);
    if (actual !== expected)
        abort_run($sformatf("FAILED at %0t: %s expected %s (%0d) got %s (%0d)",
            $time, name, expected.name(), expected, actual.name(), actual));
endtask

task automatic check_data(
    input string       name,
    input logic [63:0] expected,
    input logic [63:0] actual
);
    if (actual !== expected)
        abort_run($sformatf("FAILED at %0t: %s expected 0x%016h got 0x%016h",
            $time, name, expected, actual));
endtask

// mtime keeps counting, so a read can only be bounded
task automatic check_window(
    input string       name,
    input logic [63:0] lowest,
    input logic [63:0] highest,
    input logic [63:0] actual
);
    if (actual < lowest || actual > highest)
        abort_run($sformatf("FAILED at %0t: %s expected 0x%016h to 0x%016h got 0x%016h",
            $time, name, lowest, highest, actual));
endtask

task automatic check_irq_count(
    input string name,
    input int    expected,
    input int    actual
);
    if (actual != expected)
        abort_run($sformatf("FAILED at %0t: %s expected %0d got %0d",
            $time, name, expected, actual));
endtask

`endif

// ==== verification/clint_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "clint_consts.svh"

module clint_tb;

    import clint_pkg::*;

    localparam int HANDSHAKE_TIMEOUT = 64;
    localparam int IRQ_DISTANCE      = 40;

    logic           clk;
    logic           rst_n;
    logic [63:0]    araddr;
    logic [2:0]     arprot;
    logic [2:0]     arsize;
    logic           arvalid;
    logic           arready;
    logic [63:0]    rdata;
    axi_resp_e      rresp;
    logic           rvalid;
    logic           rready;
    logic [63:0]    awaddr;
    logic [2:0]     awprot;
    logic [2:0]     awsize;
    logic           awvalid;
    logic           awready;
    logic [63:0]    wdata;
    logic [7:0]     wstrb;
    logic           wvalid;
    logic           wready;
    axi_resp_e      bresp;
    logic           bvalid;
    logic           bready;
    logic           timer_irq;

    logic [63:0]    cycle_count;
    int             irq_count;
    logic           wr_pending;
    logic [63:0]    cmp_model;
    logic [63:0]    mtime_wr_cycle;
    int             vector_count;

    `include "clint_tb_checks.svh"

    clint_top DUT
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .araddr    (araddr),
        .arprot    (arprot),
        .arsize    (arsize),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .awaddr    (awaddr),
        .awprot    (awprot),
        .awsize    (awsize),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .timer_irq (timer_irq)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #50 clk = ~clk;
    end

    // cycle counter, irq pulse counter and the one-outstanding-write check
    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            cycle_count = '0;
            irq_count   = 0;
            wr_pending  = 1'b0;
        end
        else
        begin
            cycle_count = cycle_count + 64'd1;
            if (timer_irq)
                irq_count = irq_count + 1;
            if (awvalid && awready && wvalid && wready)
            begin
                if (wr_pending)
                    abort_run("a write was accepted while its B response was still pending");
                wr_pending = 1'b1;
            end
            if (bvalid && bready)
                wr_pending = 1'b0;
        end
    end

    // only strobed bytes take the new data
    function automatic logic [63:0] merge_bytes(
        input logic [63:0] old_value,
        input logic [63:0] new_value,
        input logic [7:0]  strb
    );
        logic [63:0] result;
        result = old_value;
        for (int i = 0; i < 8; i++)
        begin
            if (strb[i])
                result[i*8 +: 8] = new_value[i*8 +: 8];
        end
        return result;
    endfunction

    task automatic idle_cycles(input int count);
        repeat (count)
            @(negedge clk);
    endtask

    // returns on the falling edge after the AW and W transfer, valids still high
    task automatic accept_write(
        input logic [63:0] addr,
        input logic [63:0] data,
        input logic [7:0]  strb
    );
        int waits;
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wstrb   = strb;
        wvalid  = 1'b1;
        waits   = 0;
        @(negedge clk);
        while (!(awready && wready))
        begin
            waits++;
            if (waits > HANDSHAKE_TIMEOUT)
                abort_run("timeout: write address and data were never accepted");
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic finish_write(
        input  int        stall,
        output axi_resp_e resp
    );
        int waits;
        waits = 0;
        while (!bvalid)
        begin
            waits++;
            if (waits > HANDSHAKE_TIMEOUT)
                abort_run("timeout: no write response after the write was accepted");
            @(negedge clk);
        end
        idle_cycles(stall);
        if (!bvalid)
            abort_run("bvalid dropped before bready was given");
        bready = 1'b1;
        resp   = bresp;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_write(
        input  logic [63:0] addr,
        input  logic [63:0] data,
        input  logic [7:0]  strb,
        output axi_resp_e   resp,
        output logic [63:0] hs_cycle
    );
        accept_write(addr, data, strb);
        // mtime has taken the written value at the edge just passed
        hs_cycle = cycle_count;
        awvalid  = 1'b0;
        wvalid   = 1'b0;
        // back-pressure on B
        finish_write($urandom % 4, resp);
    endtask

    task automatic axi_read(
        input  logic [63:0] addr,
        output logic [63:0] data,
        output axi_resp_e   resp,
        output logic [63:0] hs_cycle
    );
        int          waits;
        int          stall;
        logic [63:0] first_data;
        araddr  = addr;
        arvalid = 1'b1;
        waits   = 0;
        @(negedge clk);
        while (!arready)
        begin
            waits++;
            if (waits > HANDSHAKE_TIMEOUT)
                abort_run("timeout: read address was never accepted");
            @(negedge clk);
        end
        @(negedge clk);
        arvalid = 1'b0;
        waits   = 0;
        while (!rvalid)
        begin
            waits++;
            if (waits > HANDSHAKE_TIMEOUT)
                abort_run("timeout: no read data after the address was accepted");
            @(negedge clk);
        end
        first_data = rdata;
        stall      = $urandom % 4;
        idle_cycles(stall);
        if (!rvalid)
            abort_run("rvalid dropped before rready was given");
        check_data("rdata held under back-pressure", first_data, rdata);
        rready   = 1'b1;
        hs_cycle = cycle_count;
        data     = rdata;
        resp     = rresp;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic wait_for_irq(input int target, input int limit);
        int waits;
        waits = 0;
        while (irq_count < target)
        begin
            waits++;
            if (waits > limit)
                abort_run("timeout: timer interrupt was not raised in time");
            @(negedge clk);
        end
    endtask

    task automatic run_vector(
        input string       op,
        input logic [63:0] addr,
        input logic [63:0] data,
        input logic [7:0]  strb,
        input axi_resp_e   exp_resp,
        input logic [63:0] exp_value,
        input string       kind
    );
        axi_resp_e   resp;
        logic [63:0] value;
        logic [63:0] hs_cycle;
        if (op == "W")
        begin
            axi_write(addr, data, strb, resp, hs_cycle);
            check_resp("bresp", exp_resp, resp);
            if (exp_resp == RESP_OKAY && addr[15:0] == `CLINT_MTIMECMP_OFFSET)
                cmp_model = merge_bytes(cmp_model, data, strb);
            if (exp_resp == RESP_OKAY && addr[15:0] == `CLINT_MTIME_OFFSET)
                mtime_wr_cycle = hs_cycle;
        end
        else if (op == "R")
        begin
            axi_read(addr, value, resp, hs_cycle);
            check_resp("rresp", exp_resp, resp);
            if (kind == "E")
                check_data("rdata", exp_value, value);
            else if (kind == "S")
                check_data("rdata of mtimecmp", cmp_model, value);
            else if (kind == "M")
                check_window("rdata of mtime", exp_value,
                    exp_value + (hs_cycle - mtime_wr_cycle), value);
            else
                abort_run({"unknown value kind in vector file: ", kind});
        end
        else
        begin
            abort_run({"unknown operation in vector file: ", op});
        end
        vector_count++;
    endtask

    initial
    begin
        int          fd;
        int          fields;
        int          irq_base;
        string       line;
        string       op;
        string       kind;
        logic [63:0] addr;
        logic [63:0] data;
        logic [63:0] exp_value;
        logic [7:0]  strb;
        logic [1:0]  resp_code;
        axi_resp_e   resp;
        logic [63:0] value;
        logic [63:0] hs_cycle;

        void'($urandom(32'ha692_c66d));
        rst_n   = 1'b0;
        araddr  = '0;
        arprot  = 3'd0;
        arsize  = 3'd3;
        arvalid = 1'b0;
        rready  = 1'b0;
        awaddr  = '0;
        awprot  = 3'd0;
        awsize  = 3'd3;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        cmp_model      = `CLINT_MTIMECMP_RESET;
        mtime_wr_cycle = '0;
        vector_count   = 0;
        repeat (5)
            @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        fd = $fopen("verification/clint_vectors.txt", "r");
        if (fd == 0)
            abort_run("could not open verification/clint_vectors.txt");
        while ($fgets(line, fd) != 0)
        begin
            fields = $sscanf(line, "%s %h %h %h %h %h %s",
                op, addr, data, strb, resp_code, exp_value, kind);
            if (fields == 7 && op != "#")
                run_vector(op, addr, data, strb, axi_resp_e'(resp_code), exp_value, kind);
        end
        $fclose(fd);
        if (vector_count == 0)
            abort_run("no vectors were read from the vector file");

        // mtimecmp below mtime gives a single pulse
        axi_write({48'd0, `CLINT_MTIMECMP_OFFSET}, '1, 8'hff, resp, hs_cycle);
        check_resp("bresp", RESP_OKAY, resp);
        idle_cycles(4);
        irq_base = irq_count;
        axi_write({48'd0, `CLINT_MTIMECMP_OFFSET}, '0, 8'hff, resp, hs_cycle);
        check_resp("bresp", RESP_OKAY, resp);
        idle_cycles(8);
        check_irq_count("timer_irq pulses with mtimecmp below mtime", irq_base + 1, irq_count);

        // mtimecmp a little ahead of mtime
        axi_write({48'd0, `CLINT_MTIMECMP_OFFSET}, '1, 8'hff, resp, hs_cycle);
        check_resp("bresp", RESP_OKAY, resp);
        idle_cycles(4);
        irq_base = irq_count;
        axi_read({48'd0, `CLINT_MTIME_OFFSET}, value, resp, hs_cycle);
        check_resp("rresp", RESP_OKAY, resp);
        axi_write({48'd0, `CLINT_MTIMECMP_OFFSET}, value + IRQ_DISTANCE, 8'hff, resp, hs_cycle);
        check_resp("bresp", RESP_OKAY, resp);
        check_irq_count("timer_irq pulses before mtime reaches mtimecmp", irq_base, irq_count);
        wait_for_irq(irq_base + 1, IRQ_DISTANCE + 8);
        idle_cycles(20);
        check_irq_count("timer_irq pulses after the compare point", irq_base + 1, irq_count);

        // next write is offered while B of the previous one is held back
        accept_write({48'd0, `CLINT_MTIMECMP_OFFSET}, 64'h0000_0000_0000_1000, 8'hff);
        wdata = 64'h0000_0000_0000_2000;
        finish_write(6, resp);
        check_resp("bresp", RESP_OKAY, resp);
        accept_write({48'd0, `CLINT_MTIMECMP_OFFSET}, 64'h0000_0000_0000_2000, 8'hff);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        finish_write($urandom % 4, resp);
        check_resp("bresp", RESP_OKAY, resp);
        axi_read({48'd0, `CLINT_MTIMECMP_OFFSET}, value, resp, hs_cycle);
        check_resp("rresp", RESP_OKAY, resp);
        check_data("rdata of mtimecmp", 64'h0000_0000_0000_2000, value);

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/clint_top.sv ====
`timescale 1ns/100ps
`default_nettype none

// single-hart CLINT with a 64-bit AXI4-Lite slave port
// prot and size are accepted but not checked, every access is one 64-bit beat
module clint_top
(
    input  wire logic               clk,
    input  wire logic               rst_n,

    input  wire logic [63:0]        araddr,
    input  wire logic [2:0]         arprot,
    input  wire logic [2:0]         arsize,
    input  wire logic               arvalid,
    output logic                    arready,

    output logic [63:0]             rdata,
    output clint_pkg::axi_resp_e    rresp,
    output logic                    rvalid,
    input  wire logic               rready,

    input  wire logic [63:0]        awaddr,
    input  wire logic [2:0]         awprot,
    input  wire logic [2:0]         awsize,
    input  wire logic               awvalid,
    output logic                    awready,

    input  wire logic [63:0]        wdata,
    input  wire logic [7:0]         wstrb,
    input  wire logic               wvalid,
    output logic                    wready,

    output clint_pkg::axi_resp_e    bresp,
    output logic                    bvalid,
    input  wire logic               bready,

    output logic                    timer_irq
);

    logic           mtime_wr;
    logic           mtimecmp_wr;
    logic [63:0]    wr_data;
    logic [7:0]     wr_strb;
    logic [63:0]    mtime;
    logic [63:0]    mtimecmp;

    clint_axi_wr_fsm u_wr_fsm
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wvalid      (wvalid),
        .awready     (awready),
        .wready      (wready),
        .bvalid      (bvalid),
        .bresp       (bresp),
        .mtime_wr    (mtime_wr),
        .mtimecmp_wr (mtimecmp_wr),
        .wr_data     (wr_data),
        .wr_strb     (wr_strb),
        .bready      (bready)
    );

    // read side runs independently of the write side
    clint_axi_rd_fsm u_rd_fsm
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .rready   (rready),
        .mtime    (mtime),
        .mtimecmp (mtimecmp),
        .arready  (arready),
        .rvalid   (rvalid),
        .rdata    (rdata),
        .rresp    (rresp)
    );

    clint_mtime_counter u_mtime
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .mtime_wr (mtime_wr),
        .wr_data  (wr_data),
        .wr_strb  (wr_strb),
        .mtime    (mtime)
    );

    clint_timer_compare u_cmp
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .mtimecmp_wr (mtimecmp_wr),
        .wr_data     (wr_data),
        .wr_strb     (wr_strb),
        .mtime       (mtime),
        .mtimecmp    (mtimecmp),
        .timer_irq   (timer_irq)
    );

endmodule

`default_nettype wire

// ==== hw/clint_timer_compare.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "clint_consts.svh"

module clint_timer_compare
(
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire logic           mtimecmp_wr,
    input  wire logic [63:0]    wr_data,
    input  wire logic [7:0]     wr_strb,
    input  wire logic [63:0]    mtime,
    output logic [63:0]         mtimecmp,
    output logic                timer_irq
);

    logic cmp_q;
    logic cmp_prev;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mtimecmp <= `CLINT_MTIMECMP_RESET;
        end
        else if (mtimecmp_wr)
        begin
            for (int i = 0; i < 8; i++)
            begin
                if (wr_strb[i])
                    mtimecmp[i*8 +: 8] <= wr_data[i*8 +: 8];
            end
        end
    end

    // 64-bit compare is registered once to keep it off the irq path
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cmp_q     <= 1'b0;
            cmp_prev  <= 1'b0;
            timer_irq <= 1'b0;
        end
        else
        begin
            cmp_q     <= (mtime >= mtimecmp);
            cmp_prev  <= cmp_q;
            // pulse on the rising edge of the registered compare
            timer_irq <= cmp_q && !cmp_prev;
        end
    end

    a_irq_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        timer_irq |=> !timer_irq
    );

endmodule

`default_nettype wire

// ==== hw/clint_mtime_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

module clint_mtime_counter
(
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire logic           mtime_wr,
    input  wire logic [63:0]    wr_data,
    input  wire logic [7:0]     wr_strb,
    output logic [63:0]         mtime
);

    logic [63:0] wr_merged;

    // replace only the strobed bytes, keep the rest of the current count
    always_comb
    begin
        wr_merged = mtime;
        for (int i = 0; i < 8; i++)
        begin
            if (wr_strb[i])
                wr_merged[i*8 +: 8] = wr_data[i*8 +: 8];
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mtime <= '0;
        end
        else if (mtime_wr)
        begin
            // a write cycle does not count
            mtime <= wr_merged;
        end
        else
        begin
            mtime <= mtime + 64'd1;
        end
    end

endmodule

`default_nettype wire

// ==== hw/clint_axi_rd_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "clint_consts.svh"

module clint_axi_rd_fsm
(
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic [63:0]        araddr,
    input  wire logic               arvalid,
    input  wire logic               rready,
    input  wire logic [63:0]        mtime,
    input  wire logic [63:0]        mtimecmp,
    output logic                    arready,
    output logic                    rvalid,
    output logic [63:0]             rdata,
    output clint_pkg::axi_resp_e    rresp
);

    import clint_pkg::*;

    rd_state_e                          state;
    logic [`CLINT_ADDR_DECODE_BITS-1:0] addr_q;
    clint_reg_e                         rd_sel;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= RD_IDLE;
            rresp <= RESP_OKAY;
        end
        else
        begin
            case (state)
                RD_IDLE:
                begin
                    if (arvalid)
                        state <= RD_ACCEPT;
                end
                RD_ACCEPT:
                begin
                    state <= RD_DATA;
                    rresp <= (rd_sel == REG_NONE) ? RESP_SLVERR : RESP_OKAY;
                end
                RD_DATA:
                begin
                    if (rready)
                        state <= RD_IDLE;
                end
                default:
                    state <= RD_IDLE;
            endcase
        end
    end

    assign rd_sel = decode_offset(addr_q);

    always_ff @(posedge clk)
    begin
        if (state == RD_IDLE && arvalid)
            addr_q <= araddr[`CLINT_ADDR_DECODE_BITS-1:0];
        // snapshot at acceptance, mtime keeps running behind it
        if (state == RD_ACCEPT)
        begin
            case (rd_sel)
                REG_MTIME:    rdata <= mtime;
                REG_MTIMECMP: rdata <= mtimecmp;
                default:      rdata <= '0;
            endcase
        end
    end

    assign arready = (state == RD_ACCEPT);
    assign rvalid  = (state == RD_DATA);

    a_rdata_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
    );

endmodule

`default_nettype wire

// ==== hw/clint_axi_wr_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "clint_consts.svh"

module clint_axi_wr_fsm
(
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic [63:0]        awaddr,
    input  wire logic               awvalid,
    input  wire logic [63:0]        wdata,
    input  wire logic [7:0]         wstrb,
    input  wire logic               wvalid,
    output logic                    awready,
    output logic                    wready,
    output logic                    bvalid,
    output clint_pkg::axi_resp_e    bresp,
    output logic                    mtime_wr,
    output logic                    mtimecmp_wr,
    output logic [63:0]             wr_data,
    output logic [7:0]              wr_strb,
    input  wire logic               bready
);

    import clint_pkg::*;

    wr_state_e                          state;
    logic [`CLINT_ADDR_DECODE_BITS-1:0] addr_q;
    clint_reg_e                         wr_sel;
    logic                               start;

    // address and data must both be present, no outstanding transactions
    assign start = (state == WR_IDLE) && awvalid && wvalid;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= WR_IDLE;
            bresp <= RESP_OKAY;
        end
        else
        begin
            case (state)
                WR_IDLE:
                begin
                    if (start)
                        state <= WR_ACCEPT;
                end
                WR_ACCEPT:
                begin
                    state <= WR_RESP;
                    bresp <= (wr_sel == REG_NONE) ? RESP_SLVERR : RESP_OKAY;
                end
                WR_RESP:
                begin
                    // hold the response until the master takes it
                    if (bready)
                        state <= WR_IDLE;
                end
                default:
                    state <= WR_IDLE;
            endcase
        end
    end

    // pair the address with its data
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            addr_q  <= awaddr[`CLINT_ADDR_DECODE_BITS-1:0];
            wr_data <= wdata;
            wr_strb <= wstrb;
        end
    end

    assign wr_sel = decode_offset(addr_q);

    // both channels handshake in the same single cycle
    assign awready = (state == WR_ACCEPT);
    assign wready  = (state == WR_ACCEPT);
    assign bvalid  = (state == WR_RESP);

    // unmapped offsets raise no strobe
    assign mtime_wr    = (state == WR_ACCEPT) && (wr_sel == REG_MTIME);
    assign mtimecmp_wr = (state == WR_ACCEPT) && (wr_sel == REG_MTIMECMP);

    a_wr_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(mtime_wr && mtimecmp_wr)
    );

    a_bvalid_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid
    );

endmodule

`default_nettype wire

// ==== hw/clint_pkg.sv ====
`default_nettype none

`include "clint_consts.svh"

package clint_pkg;

    // register targeted by an access
    typedef enum logic [1:0]
    {
        REG_NONE     = 2'd0,
        REG_MTIME    = 2'd1,
        REG_MTIMECMP = 2'd2
    } clint_reg_e;

    // AXI response codes used by this slave
    typedef enum logic [1:0]
    {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

    // write channel states
    typedef enum logic [1:0]
    {
        WR_IDLE   = 2'd0,
        WR_ACCEPT = 2'd1,
        WR_RESP   = 2'd2
    } wr_state_e;

    // read channel states
    typedef enum logic [1:0]
    {
        RD_IDLE   = 2'd0,
        RD_ACCEPT = 2'd1,
        RD_DATA   = 2'd2
    } rd_state_e;

    // map the decoded offset bits to a register
    function automatic clint_reg_e decode_offset(
        input logic [`CLINT_ADDR_DECODE_BITS-1:0] offset
    );
        clint_reg_e sel;
        case (offset)
            `CLINT_MTIME_OFFSET:    sel = REG_MTIME;
            `CLINT_MTIMECMP_OFFSET: sel = REG_MTIMECMP;
            default:                sel = REG_NONE;
        endcase
        return sel;
    endfunction

endpackage

`default_nettype wire

// ==== hw/clint_consts.svh ====
`ifndef CLINT_CONSTS_SVH
`define CLINT_CONSTS_SVH

// register map of the single-hart CLINT

// offsets are taken relative to the CLINT base, only the low bits are decoded
`define CLINT_ADDR_DECODE_BITS 16

// timer compare register for hart 0
`define CLINT_MTIMECMP_OFFSET 16'h4000

// free-running machine timer
`define CLINT_MTIME_OFFSET 16'hbff8

// compare value after reset
// small and nonzero, so the first interrupt comes shortly after reset
`define CLINT_MTIMECMP_RESET 64'h20

`endif
